/* source/ctrl_pkg.sv */
package ctrl_pkg;

  //////////////////////////////////////////////////
  // qmem bus widths
  //////////////////////////////////////////////////

  // word address space of the control block
  localparam int QAW = 22;
  // data word
  localparam int QDW = 32;

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////

  // slot index is address bits 4..2
  typedef enum logic [2:0] {
    REG_RST       = 3'd0,
    REG_CTRL      = 3'd1,
    REG_UART_TX   = 3'd2,
    REG_TIMER     = 3'd3,
    REG_SPI_DIV   = 3'd4,
    REG_SPI_CS    = 3'd5,
    REG_SPI_DAT   = 3'd6,
    REG_SPI_BLOCK = 3'd7
  } reg_idx_t;

  // bus owner in the arbiter
  typedef enum logic {
    OWN_CPU = 1'b0,
    OWN_DBG = 1'b1
  } owner_t;

  // spi sequencer
  typedef enum logic [1:0] {
    SPI_IDLE  = 2'd0,
    SPI_SHIFT = 2'd1,
    SPI_TAIL  = 2'd2
  } spi_state_t;

endpackage

/* source/ctrl_ifs.sv */
`timescale 1ns/1ps

// qmem request/ack bus
// master holds the request until ack seen at a rising edge
interface qmem_if;
  import ctrl_pkg::*;

  logic [QAW-1:0] adr;
  logic           cs;
  logic           we;
  logic [QDW-1:0] dat_w;
  // valid one cycle after the read ack
  logic [QDW-1:0] dat_r;
  // combinational from the slave
  logic           ack;

  modport master (output adr, cs, we, dat_w, input dat_r, ack);
  modport slave  (input adr, cs, we, dat_w, output dat_r, ack);

endinterface

// register decoder to spi master
interface spi_reg_if;
  import ctrl_pkg::*;

  // one-cycle write strobes
  logic           wr_div;
  logic           wr_cs;
  logic           wr_dat;
  logic           wr_block;
  logic [QDW-1:0] wdata;
  // status back from the shifter
  logic           busy;
  logic [7:0]     rd_byte;
  logic [5:0]     div_val;

  modport decoder (
    output wr_div, wr_cs, wr_dat, wr_block, wdata,
    input  busy, rd_byte, div_val
  );
  modport peripheral (
    input  wr_div, wr_cs, wr_dat, wr_block, wdata,
    output busy, rd_byte, div_val
  );

endinterface

/* source/qmem_arbiter.sv */
`timescale 1ns/1ps

module qmem_arbiter (
  input  logic   clk,
  input  logic   rst,
  qmem_if.slave  cpu,
  qmem_if.slave  dbg,
  qmem_if.master bus
);
  import ctrl_pkg::*;

  owner_t owner;
  owner_t grant;
  owner_t other;
  owner_t rd_owner;
  logic   lock;
  logic   gnt_cs;
  logic   other_cs;
  logic   done;

  //////////////////////////////////////////////////
  // grant, combinational
  //////////////////////////////////////////////////

  // locked owner keeps the bus, else owner has priority
  always_comb begin
    if (lock) begin
      grant = owner;
    end else if (owner == OWN_CPU) begin
      grant = (cpu.cs || !dbg.cs) ? OWN_CPU : OWN_DBG;
    end else begin
      grant = (dbg.cs || !cpu.cs) ? OWN_DBG : OWN_CPU;
    end
  end

  assign other    = (grant == OWN_CPU) ? OWN_DBG : OWN_CPU;
  assign gnt_cs   = (grant == OWN_CPU) ? cpu.cs : dbg.cs;
  assign other_cs = (grant == OWN_CPU) ? dbg.cs : cpu.cs;
  // transfer ends at this edge
  assign done     = gnt_cs && bus.ack;

  // request mux onto the slave
  assign bus.adr   = (grant == OWN_CPU) ? cpu.adr : dbg.adr;
  assign bus.we    = (grant == OWN_CPU) ? cpu.we : dbg.we;
  assign bus.dat_w = (grant == OWN_CPU) ? cpu.dat_w : dbg.dat_w;
  assign bus.cs    = gnt_cs;

  // ack only to the granted side, the other one waits
  assign cpu.ack = (grant == OWN_CPU) && bus.ack;
  assign dbg.ack = (grant == OWN_DBG) && bus.ack;

  // read data trails ack by one cycle
  assign cpu.dat_r = (rd_owner == OWN_CPU) ? bus.dat_r : '0;
  assign dbg.dat_r = (rd_owner == OWN_DBG) ? bus.dat_r : '0;

  //////////////////////////////////////////////////
  // owner and lock
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner    <= OWN_CPU;
      lock     <= 1'b0;
      rd_owner <= OWN_CPU;
    end else if (done) begin
      // hand over if the other side is waiting
      lock     <= 1'b0;
      owner    <= other_cs ? other : grant;
      rd_owner <= grant;
    end else begin
      lock  <= gnt_cs;
      owner <= grant;
    end
  end

endmodule

/* source/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs (
  input  logic        clk,
  input  logic        rst,
  qmem_if.slave       bus,
  input  logic [3:0]  ctrl_cfg,
  output logic [3:0]  ctrl_status,
  output logic        sys_rst,
  output logic        aux_rst,
  output logic        tx_wr,
  output logic [7:0]  tx_byte,
  input  logic        tx_ready,
  output logic        tmr_wr,
  output logic [15:0] tmr_load,
  input  logic [15:0] tmr_count,
  spi_reg_if.decoder  spi
);
  import ctrl_pkg::*;

  reg_idx_t   idx;
  reg_idx_t   rd_idx;
  logic       slot_rdy;
  logic       wr;
  logic [7:0] wr_sel;

  //////////////////////////////////////////////////
  // decode and ack
  //////////////////////////////////////////////////

  assign idx = reg_idx_t'(bus.adr[4:2]);

  // uart stalls while shifting, spi while busy
  always_comb begin
    case (idx)
      REG_UART_TX: slot_rdy = tx_ready;
      REG_SPI_DIV,
      REG_SPI_CS,
      REG_SPI_DAT,
      REG_SPI_BLOCK: slot_rdy = !spi.busy;
      default: slot_rdy = 1'b1;
    endcase
  end

  assign bus.ack = bus.cs && slot_rdy;

  // one-hot strobe, only in the ack cycle
  assign wr     = bus.ack && bus.we;
  assign wr_sel = wr ? (8'd1 << idx) : 8'd0;

  // peripheral strobes and data
  assign tx_wr        = wr_sel[REG_UART_TX];
  assign tx_byte      = bus.dat_w[7:0];
  assign tmr_wr       = wr_sel[REG_TIMER];
  assign tmr_load     = bus.dat_w[15:0];
  assign spi.wr_div   = wr_sel[REG_SPI_DIV];
  assign spi.wr_cs    = wr_sel[REG_SPI_CS];
  assign spi.wr_dat   = wr_sel[REG_SPI_DAT];
  assign spi.wr_block = wr_sel[REG_SPI_BLOCK];
  assign spi.wdata    = bus.dat_w;

  //////////////////////////////////////////////////
  // reset and status bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sys_rst <= 1'b0;
      aux_rst <= 1'b0;
    end else if (wr_sel[REG_RST]) begin
      sys_rst <= bus.dat_w[0];
      aux_rst <= bus.dat_w[1];
    end
  end

  // status nibble lives in bits 19..16
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl_status <= 4'd0;
    end else if (wr_sel[REG_CTRL]) begin
      ctrl_status <= bus.dat_w[19:16];
    end
  end

  //////////////////////////////////////////////////
  // read path
  //////////////////////////////////////////////////

  // slot of the last acked access
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_idx <= REG_RST;
    end else if (bus.ack) begin
      rd_idx <= idx;
    end
  end

  // write-only slots read as zero
  always_comb begin
    case (rd_idx)
      REG_CTRL:    bus.dat_r = {{(QDW-4){1'b0}}, ctrl_cfg};
      REG_TIMER:   bus.dat_r = {{(QDW-16){1'b0}}, tmr_count};
      REG_SPI_DIV: bus.dat_r = {{(QDW-6){1'b0}}, spi.div_val};
      REG_SPI_DAT: bus.dat_r = {{(QDW-8){1'b0}}, spi.rd_byte};
      default:     bus.dat_r = '0;
    endcase
  end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLK_PER_BIT = 434
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       tx_wr,
  input  logic [7:0] tx_byte,
  output logic       tx_ready,
  output logic       txd
);

  localparam int TW = $clog2(CLK_PER_BIT + 1);
  localparam logic [TW-1:0] BIT_LAST = TW'(CLK_PER_BIT - 1);

  logic [TW-1:0] bit_tmr;
  logic [3:0]    bit_cnt;
  logic [9:0]    shreg;
  logic          bit_end;
  logic          start;

  assign bit_end  = (bit_tmr == '0);
  assign tx_ready = bit_end && (bit_cnt == 4'd0);
  assign start    = tx_wr && tx_ready;

  // bit timer, reloads while bits remain
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_tmr <= '0;
    end else if (start) begin
      bit_tmr <= BIT_LAST;
    end else if (!bit_end) begin
      bit_tmr <= bit_tmr - 1'b1;
    end else if (bit_cnt != 4'd0) begin
      bit_tmr <= BIT_LAST;
    end
  end

  // bits left after the current one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_cnt <= 4'd0;
    end else if (start) begin
      bit_cnt <= 4'd9;
    end else if (bit_end && (bit_cnt != 4'd0)) begin
      bit_cnt <= bit_cnt - 4'd1;
    end
  end

  // stop, data lsb first, start; idle line high
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shreg <= 10'h3ff;
    end else if (start) begin
      shreg <= {1'b1, tx_byte, 1'b0};
    end else if (bit_end && (bit_cnt != 4'd0)) begin
      shreg <= {1'b1, shreg[9:1]};
    end
  end

  assign txd = shreg[0];

endmodule

/* source/ms_timer.sv */
`timescale 1ns/1ps

module ms_timer #(
  parameter int CLK_PER_TICK = 50000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        tmr_wr,
  input  logic [15:0] tmr_load,
  output logic [15:0] count
);

  localparam int PW = $clog2(CLK_PER_TICK + 1);
  localparam logic [PW-1:0] PRE_LAST = PW'(CLK_PER_TICK - 1);

  logic [PW-1:0] pre;
  logic          tick;

  // prescaler wraps once per tick
  assign tick = (pre == '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pre   <= PRE_LAST;
      count <= 16'd0;
    end else if (tmr_wr) begin
      // load also restarts the tick period
      pre   <= PRE_LAST;
      count <= tmr_load;
    end else if (tick) begin
      pre   <= PRE_LAST;
      count <= count + 16'd1;
    end else begin
      pre <= pre - 1'b1;
    end
  end

endmodule

/* source/spi_master.sv */
`timescale 1ns/1ps

// mode 3: clock idles high, out on falling, in on rising
module spi_master #(
  parameter int SPI_DIV_RESET = 62
) (
  input  logic          clk,
  input  logic          rst,
  spi_reg_if.peripheral regs,
  output logic          spi_clk,
  output logic          spi_do,
  input  logic          spi_di,
  output logic [3:0]    spi_cs_n
);
  import ctrl_pkg::*;

  spi_state_t state;
  logic [5:0] div_r;
  logic [5:0] div_cnt;
  logic [3:0] half_cnt;
  logic [9:0] block;
  logic [7:0] sh_out;
  logic [7:0] sh_in;
  logic       half_end;
  logic       last_half;
  logic       toggle;
  logic [3:0] cs_mask;
  logic [3:0] cs_val;
  logic [3:0] cs_act;

  assign half_end  = (div_cnt == 6'd0);
  assign last_half = (half_cnt == 4'd15);
  // clock edge due, except the final high half of the last byte
  assign toggle = (state == SPI_SHIFT) && half_end && !(last_half && (block == 10'd0));

  //////////////////////////////////////////////////
  // config registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      div_r <= 6'(SPI_DIV_RESET);
    end else if (regs.wr_div) begin
      div_r <= regs.wdata[5:0];
    end
  end

  // masked write touches only positions set in 7..4
  assign cs_mask = regs.wdata[7:4];
  assign cs_val  = regs.wdata[3:0];
  assign cs_act  = (|cs_mask) ? ((cs_mask & cs_val) | (~cs_mask & ~spi_cs_n)) : cs_val;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      spi_cs_n <= 4'b1111;
    end else if (regs.wr_cs) begin
      spi_cs_n <= ~cs_act;
    end
  end

  // extra bytes, counted down at each byte boundary
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      block <= 10'd0;
    end else if (regs.wr_block) begin
      block <= regs.wdata[9:0];
    end else if (toggle && last_half) begin
      block <= block - 10'd1;
    end
  end

  //////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= SPI_IDLE;
      div_cnt  <= 6'd0;
      half_cnt <= 4'd0;
      spi_clk  <= 1'b1;
    end else begin
      case (state)
        SPI_IDLE: begin
          // first falling edge right at start
          if (regs.wr_dat) begin
            state    <= SPI_SHIFT;
            div_cnt  <= div_r;
            half_cnt <= 4'd0;
            spi_clk  <= 1'b0;
          end
        end
        SPI_SHIFT: begin
          if (!half_end) begin
            div_cnt <= div_cnt - 6'd1;
          end else begin
            div_cnt <= div_r;
            if (toggle) begin
              spi_clk  <= ~spi_clk;
              half_cnt <= half_cnt + 4'd1;
            end else begin
              state <= SPI_TAIL;
            end
          end
        end
        SPI_TAIL: begin
          // one more half period with clock high
          if (!half_end) begin
            div_cnt <= div_cnt - 6'd1;
          end else begin
            state <= SPI_IDLE;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // shifters
  //////////////////////////////////////////////////

  // rotate so the byte is back in place after 8 falls
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sh_out <= 8'hff;
    end else if ((state == SPI_IDLE) && regs.wr_dat) begin
      sh_out <= regs.wdata[7:0];
    end else if (toggle && spi_clk) begin
      sh_out <= {sh_out[6:0], sh_out[7]};
    end
  end

  // sample on rising edge
  always_ff @(posedge clk) begin
    if (toggle && !spi_clk) begin
      sh_in <= {sh_in[6:0], spi_di};
    end
  end

  assign spi_do       = sh_out[7];
  assign regs.busy    = (state != SPI_IDLE);
  assign regs.rd_byte = sh_in;
  assign regs.div_val = div_r;

endmodule

/* source/ctrl_top.sv */
`timescale 1ns/1ps

module ctrl_top #(
  parameter int CLK_PER_BIT   = 434,
  parameter int CLK_PER_TICK  = 50000,
  parameter int SPI_DIV_RESET = 62
) (
  input  logic                     clk,
  input  logic                     rst,
  // processor port
  input  logic [ctrl_pkg::QAW-1:0] cpu_adr,
  input  logic                     cpu_cs,
  input  logic                     cpu_we,
  input  logic [ctrl_pkg::QDW-1:0] cpu_dat_w,
  output logic [ctrl_pkg::QDW-1:0] cpu_dat_r,
  output logic                     cpu_ack,
  // debug port
  input  logic [ctrl_pkg::QAW-1:0] dbg_adr,
  input  logic                     dbg_cs,
  input  logic                     dbg_we,
  input  logic [ctrl_pkg::QDW-1:0] dbg_dat_w,
  output logic [ctrl_pkg::QDW-1:0] dbg_dat_r,
  output logic                     dbg_ack,
  // pins
  input  logic [3:0]               ctrl_cfg,
  output logic [3:0]               ctrl_status,
  output logic                     sys_rst,
  output logic                     aux_rst,
  output logic                     uart_txd,
  output logic [3:0]               spi_cs_n,
  output logic                     spi_clk,
  output logic                     spi_do,
  input  logic                     spi_di
);

  logic        tx_wr;
  logic [7:0]  tx_byte;
  logic        tx_ready;
  logic        tmr_wr;
  logic [15:0] tmr_load;
  logic [15:0] tmr_count;

  qmem_if    cpu_q ();
  qmem_if    dbg_q ();
  qmem_if    reg_q ();
  spi_reg_if spi_q ();

  //////////////////////////////////////////////////
  // master ports onto the bus
  //////////////////////////////////////////////////

  assign cpu_q.adr   = cpu_adr;
  assign cpu_q.cs    = cpu_cs;
  assign cpu_q.we    = cpu_we;
  assign cpu_q.dat_w = cpu_dat_w;
  assign cpu_dat_r   = cpu_q.dat_r;
  assign cpu_ack     = cpu_q.ack;

  assign dbg_q.adr   = dbg_adr;
  assign dbg_q.cs    = dbg_cs;
  assign dbg_q.we    = dbg_we;
  assign dbg_q.dat_w = dbg_dat_w;
  assign dbg_dat_r   = dbg_q.dat_r;
  assign dbg_ack     = dbg_q.ack;

  qmem_arbiter arb0 (
    .clk (clk),
    .rst (rst),
    .cpu (cpu_q),
    .dbg (dbg_q),
    .bus (reg_q)
  );

  ctrl_regs regs0 (
    .clk         (clk),
    .rst         (rst),
    .bus         (reg_q),
    .ctrl_cfg    (ctrl_cfg),
    .ctrl_status (ctrl_status),
    .sys_rst     (sys_rst),
    .aux_rst     (aux_rst),
    .tx_wr       (tx_wr),
    .tx_byte     (tx_byte),
    .tx_ready    (tx_ready),
    .tmr_wr      (tmr_wr),
    .tmr_load    (tmr_load),
    .tmr_count   (tmr_count),
    .spi         (spi_q)
  );

  //////////////////////////////////////////////////
  // peripherals
  //////////////////////////////////////////////////

  uart_tx #(.CLK_PER_BIT(CLK_PER_BIT)) uart0 (
    .clk      (clk),
    .rst      (rst),
    .tx_wr    (tx_wr),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .txd      (uart_txd)
  );

  ms_timer #(.CLK_PER_TICK(CLK_PER_TICK)) tmr0 (
    .clk      (clk),
    .rst      (rst),
    .tmr_wr   (tmr_wr),
    .tmr_load (tmr_load),
    .count    (tmr_count)
  );

  spi_master #(.SPI_DIV_RESET(SPI_DIV_RESET)) spi0 (
    .clk      (clk),
    .rst      (rst),
    .regs     (spi_q),
    .spi_clk  (spi_clk),
    .spi_do   (spi_do),
    .spi_di   (spi_di),
    .spi_cs_n (spi_cs_n)
  );

endmodule

/* verification/ctrl_tb.sv */
`timescale 1ns/1ps

module ctrl_tb;
  import ctrl_pkg::*;

  // shortened peripheral timing
  localparam int UART_CPB  = 8;
  localparam int TICK_CLKS = 20;
  localparam int DIV_RESET = 1;
  // well above the roughly 1500 cycles of all tests
  localparam int MAX_CYCLES = 20000;

  logic           clk;
  logic           rst;
  logic [QAW-1:0] cpu_adr;
  logic           cpu_cs;
  logic           cpu_we;
  logic [QDW-1:0] cpu_dat_w;
  logic [QDW-1:0] cpu_dat_r;
  logic           cpu_ack;
  logic [QAW-1:0] dbg_adr;
  logic           dbg_cs;
  logic           dbg_we;
  logic [QDW-1:0] dbg_dat_w;
  logic [QDW-1:0] dbg_dat_r;
  logic           dbg_ack;
  logic [3:0]     ctrl_cfg;
  logic [3:0]     ctrl_status;
  logic           sys_rst;
  logic           aux_rst;
  logic           uart_txd;
  logic [3:0]     spi_cs_n;
  logic           spi_clk;
  logic           spi_do;
  logic           spi_di;

  int         errors = 0;
  int         checks = 0;
  int         cycles = 0;
  int         cpu_waits = 0;
  int         spi_rises = 0;
  logic [7:0] spi_cap;

  ctrl_top #(
    .CLK_PER_BIT   (UART_CPB),
    .CLK_PER_TICK  (TICK_CLKS),
    .SPI_DIV_RESET (DIV_RESET)
  ) dut0 (
    .clk (clk), .rst (rst),
    .cpu_adr (cpu_adr), .cpu_cs (cpu_cs), .cpu_we (cpu_we),
    .cpu_dat_w (cpu_dat_w), .cpu_dat_r (cpu_dat_r), .cpu_ack (cpu_ack),
    .dbg_adr (dbg_adr), .dbg_cs (dbg_cs), .dbg_we (dbg_we),
    .dbg_dat_w (dbg_dat_w), .dbg_dat_r (dbg_dat_r), .dbg_ack (dbg_ack),
    .ctrl_cfg (ctrl_cfg), .ctrl_status (ctrl_status),
    .sys_rst (sys_rst), .aux_rst (aux_rst), .uart_txd (uart_txd),
    .spi_cs_n (spi_cs_n), .spi_clk (spi_clk), .spi_do (spi_do), .spi_di (spi_di)
  );

  // spi loopback
  assign spi_di = spi_do;

  always #4 clk = ~clk;

  //////////////////////////////////////////////////
  // monitors
  //////////////////////////////////////////////////

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  // mosi bits at spi_clk rising edges in msb first order
  always @(posedge spi_clk) begin
    spi_rises <= spi_rises + 1;
    spi_cap   <= {spi_cap[6:0], spi_do};
  end

  //////////////////////////////////////////////////
  // checks and bus helpers
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, got);
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi, input int got);
    checks++;
    assert (got >= lo && got <= hi) else begin
      errors++;
      $display("[ERROR] %s: expected %0d to %0d, actual %0d", name, lo, hi, got);
    end
  endtask

  function automatic logic [QAW-1:0] reg_addr(input reg_idx_t idx);
    return {{(QAW-5){1'b0}}, idx, 2'b00};
  endfunction

  // called and returns at 1 ns after a rising edge
  task automatic cpu_access(input logic we, input reg_idx_t idx, input logic [QDW-1:0] wdata,
                            output logic [QDW-1:0] rdata);
    int waits;
    waits     = 0;
    cpu_adr   = reg_addr(idx);
    cpu_we    = we;
    cpu_dat_w = wdata;
    cpu_cs    = 1'b1;
    // ack checked at the falling edge of clk
    @(negedge clk);
    while (!cpu_ack) begin
      waits++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cpu_cs = 1'b0;
    cpu_we = 1'b0;
    rdata  = '0;
    // read data trails ack by one cycle
    if (!we) begin
      @(negedge clk);
      rdata = cpu_dat_r;
      @(posedge clk);
      #1;
    end
    cpu_waits = waits;
  endtask

  task automatic dbg_access(input logic we, input reg_idx_t idx, input logic [QDW-1:0] wdata,
                            output logic [QDW-1:0] rdata);
    dbg_adr   = reg_addr(idx);
    dbg_we    = we;
    dbg_dat_w = wdata;
    dbg_cs    = 1'b1;
    @(negedge clk);
    while (!dbg_ack) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    dbg_cs = 1'b0;
    dbg_we = 1'b0;
    rdata  = '0;
    if (!we) begin
      @(negedge clk);
      rdata = dbg_dat_r;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic cpu_write(input reg_idx_t idx, input logic [QDW-1:0] wdata);
    logic [QDW-1:0] unused;
    cpu_access(1'b1, idx, wdata, unused);
  endtask

  task automatic cpu_read(input reg_idx_t idx, output logic [QDW-1:0] rdata);
    cpu_access(1'b0, idx, '0, rdata);
  endtask

  task automatic dbg_write(input reg_idx_t idx, input logic [QDW-1:0] wdata);
    logic [QDW-1:0] unused;
    dbg_access(1'b1, idx, wdata, unused);
  endtask

  task automatic dbg_read(input reg_idx_t idx, output logic [QDW-1:0] rdata);
    dbg_access(1'b0, idx, '0, rdata);
  endtask

  // one 8N1 frame sampled at bit centers
  task automatic capture_frame(input logic [7:0] exp, input string name);
    logic [7:0] got;
    logic       start_bit;
    logic       stop_bit;
    @(negedge uart_txd);
    repeat (UART_CPB / 2) @(negedge clk);
    start_bit = uart_txd;
    for (int i = 0; i < 8; i++) begin
      repeat (UART_CPB) @(negedge clk);
      got[i] = uart_txd;
    end
    repeat (UART_CPB) @(negedge clk);
    stop_bit = uart_txd;
    check_val({name, " start"}, 0, start_bit);
    check_val({name, " data"}, exp, got);
    check_val({name, " stop"}, 1, stop_bit);
  endtask

  // byte plus extra repeats then read back
  task automatic spi_transfer(input logic [7:0] data, input int extra, input string name);
    int             rises0;
    logic [QDW-1:0] rd;
    cpu_write(REG_SPI_BLOCK, extra);
    rises0 = spi_rises;
    cpu_write(REG_SPI_DAT, {24'd0, data});
    // spi slot stalls while busy
    cpu_read(REG_SPI_DAT, rd);
    check_val({name, " rd_byte"}, data, rd);
    check_val({name, " mosi"}, data, spi_cap);
    check_val({name, " rises"}, 8 * (extra + 1), spi_rises - rises0);
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    logic [QDW-1:0] rd;
    check_val("reset sys_rst", 0, sys_rst);
    check_val("reset aux_rst", 0, aux_rst);
    check_val("reset spi_cs_n", 4'hf, spi_cs_n);
    check_val("reset spi_clk", 1, spi_clk);
    check_val("reset uart_txd", 1, uart_txd);
    check_val("reset status", 0, ctrl_status);
    // idle shifter acks at once
    cpu_read(REG_SPI_DIV, rd);
    check_val("reset spi idle", 0, cpu_waits);
    check_val("reset spi div", DIV_RESET, rd);
  endtask

  task automatic test_ctrl();
    logic [3:0]     status;
    logic [QDW-1:0] rd;
    cpu_write(REG_RST, 32'h1);
    check_val("ctrl sys_rst set", 1, sys_rst);
    check_val("ctrl aux_rst clear", 0, aux_rst);
    cpu_write(REG_RST, 32'h2);
    check_val("ctrl sys_rst clear", 0, sys_rst);
    check_val("ctrl aux_rst set", 1, aux_rst);
    cpu_write(REG_RST, 32'h0);
    status = 4'($urandom);
    cpu_write(REG_CTRL, {12'd0, status, 16'd0});
    check_val("ctrl status", status, ctrl_status);
    cpu_read(REG_CTRL, rd);
    check_val("ctrl cfg", ctrl_cfg, rd);
  endtask

  task automatic test_uart();
    logic [7:0] b0;
    logic [7:0] b1;
    b0 = 8'($urandom);
    b1 = 8'($urandom);
    fork
      begin
        cpu_write(REG_UART_TX, {24'd0, b0});
        cpu_write(REG_UART_TX, {24'd0, b1});
        // second byte waits out most of the first frame
        check_range("uart stall", 9 * UART_CPB, 10 * UART_CPB, cpu_waits);
      end
      begin
        capture_frame(b0, "uart byte 0");
        capture_frame(b1, "uart byte 1");
      end
    join
    @(posedge clk);
    #1;
  endtask

  task automatic test_timer();
    logic [QDW-1:0] rd;
    cpu_write(REG_TIMER, 32'h0100);
    repeat (200) @(posedge clk);
    #1;
    // about ten ticks of 20 cycles
    cpu_read(REG_TIMER, rd);
    check_range("timer", 16'h0100 + 9, 16'h0100 + 11, rd);
  endtask

  task automatic test_spi();
    logic [QDW-1:0] rd;
    cpu_write(REG_SPI_DIV, 32'd3);
    cpu_read(REG_SPI_DIV, rd);
    check_val("spi div", 3, rd);
    repeat (3) spi_transfer(8'($urandom), 0, "spi byte");
    spi_transfer(8'($urandom), 2, "spi block");
  endtask

  task automatic test_cs();
    // plain write makes selects 0 and 2 active
    cpu_write(REG_SPI_CS, 32'h05);
    check_val("cs plain", 4'b1010, spi_cs_n);
    // mask bit 3 only with the select inactive
    cpu_write(REG_SPI_CS, 32'h84);
    check_val("cs mask off", 4'b1010, spi_cs_n);
    cpu_write(REG_SPI_CS, 32'h88);
    check_val("cs mask on", 4'b0010, spi_cs_n);
  endtask

  task automatic test_arbitration();
    logic [QDW-1:0] cpu_rd;
    logic [QDW-1:0] dbg_rd;
    // cpu owns the bus first so dbg lands last
    fork
      cpu_write(REG_CTRL, {12'd0, 4'h3, 16'd0});
      dbg_write(REG_CTRL, {12'd0, 4'hc, 16'd0});
    join
    check_val("arb status", 4'hc, ctrl_status);
    fork
      cpu_read(REG_CTRL, cpu_rd);
      dbg_read(REG_SPI_DIV, dbg_rd);
    join
    check_val("arb cpu read", ctrl_cfg, cpu_rd);
    check_val("arb dbg read", 3, dbg_rd);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(59));
    clk       = 1'b0;
    rst       = 1'b1;
    cpu_adr   = '0;
    cpu_cs    = 1'b0;
    cpu_we    = 1'b0;
    cpu_dat_w = '0;
    dbg_adr   = '0;
    dbg_cs    = 1'b0;
    dbg_we    = 1'b0;
    dbg_dat_w = '0;
    ctrl_cfg  = 4'($urandom);
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_ctrl();
    test_uart();
    test_timer();
    test_spi();
    test_cs();
    test_arbitration();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* sim.f */
source/ctrl_pkg.sv
source/ctrl_ifs.sv
source/qmem_arbiter.sv
source/ctrl_regs.sv
source/uart_tx.sv
source/ms_timer.sv
source/spi_master.sv
source/ctrl_top.sv
verification/ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ctrl_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
PASS_MSG  := Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
